/* tb.f */
cache_params_pkg.sv
cache_types_pkg.sv
icache_stage_if.sv
icache_fill_if.sv
icache_plru.sv
icache_lookup.sv
icache_hit_logic.sv
icache_fill_ctrl.sv
icache_top.sv
tb_icache.sv

/* Makefile */
all: run

obj_dir/Vtb_icache: tb.f *.sv
	verilator --binary --timing --assert -j 0 --top-module tb_icache -f tb.f

run: obj_dir/Vtb_icache
	./obj_dir/Vtb_icache | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module icache_top -f tb.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

/* tb_icache.sv */
`timescale 1ns/10ps

module tb_icache;

    import cache_params_pkg::*;
    import cache_types_pkg::*;

    typedef struct packed {
        addr_t      addr;
        logic       pf;
        logic       hit;
        logic [3:0] reads;
    } row_t;

    localparam int    num_rows     = 16;
    localparam int    num_random   = 200;
    localparam int    reset_cycles = 16;
    localparam int    row_cycles   = 40;
    localparam word_t data_key     = 32'h5a5a_0000;

    // Address, prefetch_en, expected hit, expected memory reads
    localparam row_t stim [num_rows] = '{
        '{32'h0000_1004, 1'b0, 1'b0, 4'd1},
        '{32'h0000_101c, 1'b0, 1'b1, 4'd0},
        '{32'h0000_1000, 1'b0, 1'b1, 4'd0},
        '{32'h0000_2040, 1'b1, 1'b0, 4'd2},
        '{32'h0000_2068, 1'b1, 1'b1, 4'd0},
        '{32'h0000_2088, 1'b0, 1'b0, 4'd1},
        // L0 to L3 fill set 8, then L4 evicts L2
        '{32'h0000_4100, 1'b0, 1'b0, 4'd1},
        '{32'h0000_4304, 1'b0, 1'b0, 4'd1},
        '{32'h0000_4508, 1'b0, 1'b0, 4'd1},
        '{32'h0000_470c, 1'b0, 1'b0, 4'd1},
        '{32'h0000_4110, 1'b0, 1'b1, 4'd0},
        '{32'h0000_4914, 1'b0, 1'b0, 4'd1},
        '{32'h0000_4518, 1'b0, 1'b0, 4'd1},
        '{32'h0000_411c, 1'b0, 1'b1, 4'd0},
        '{32'h0000_4300, 1'b0, 1'b0, 4'd1},
        '{32'h0000_4704, 1'b0, 1'b0, 4'd1}
    };

    logic  clk;
    logic  rst;
    logic  prefetch_en;
    logic  cpu_read;
    addr_t cpu_addr;
    word_t cpu_rdata;
    logic  cpu_resp;
    logic  mem_read;
    addr_t mem_addr;
    line_t mem_rdata;
    logic  mem_resp;

    // Reference model state
    valid_vec_t m_valid [num_sets];
    tag_t       m_tag   [num_sets][num_ways];
    plru_t      m_plru  [num_sets];

    addr_t       exp_q [$];
    addr_t       seen_q [$];
    int          mem_reads = 0;
    int          model_reads = 0;
    int          errors = 0;
    int          tests_failed = 0;
    logic [31:0] mem_rng = 32'd67;
    logic [31:0] stim_rng = 32'd67;

    icache_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .prefetch_en (prefetch_en),
        .cpu_read    (cpu_read),
        .cpu_addr    (cpu_addr),
        .cpu_rdata   (cpu_rdata),
        .cpu_resp    (cpu_resp),
        .mem_read    (mem_read),
        .mem_addr    (mem_addr),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Every word holds its own byte address scrambled by the key
    function automatic line_t line_at(addr_t base);
        line_t l;
        for (int i = 0; i < 8; i++) begin
            l[32*i +: 32] = (base + addr_t'(4 * i)) ^ data_key;
        end
        return l;
    endfunction

    function automatic word_t expected_word(addr_t addr);
        return {addr[31:2], 2'b00} ^ data_key;
    endfunction

    // Memory answers 1 to 4 cycles after it sees mem_read
    initial begin
        addr_t req_addr;
        int    delay;
        mem_resp  = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (mem_read && !rst) begin
                req_addr = mem_addr;
                mem_rng  = xorshift32(mem_rng);
                delay    = 1 + int'(mem_rng % 4);
                mem_reads++;
                seen_q.push_back(req_addr);
                repeat (delay) @(posedge clk);
                mem_resp  <= 1'b1;
                mem_rdata <= line_at(req_addr);
                @(posedge clk);
                mem_resp  <= 1'b0;
            end
        end
    end

    function automatic plru_t model_touch(plru_t p, way_t w);
        plru_t n;
        n = p;
        case (w)
            2'd0: begin
                n[0] = 1'b1;
                n[1] = 1'b1;
            end
            2'd1: begin
                n[0] = 1'b1;
                n[1] = 1'b0;
            end
            2'd2: begin
                n[0] = 1'b0;
                n[2] = 1'b1;
            end
            default: begin
                n[0] = 1'b0;
                n[2] = 1'b0;
            end
        endcase
        return n;
    endfunction

    function automatic way_t model_victim(plru_t p);
        if (!p[0]) begin
            return p[1] ? 2'd1 : 2'd0;
        end
        return p[2] ? 2'd3 : 2'd2;
    endfunction

    task automatic model_find(input addr_t addr, output logic hit, output way_t way);
        index_t idx;
        idx = addr[8:5];
        hit = 1'b0;
        way = '0;
        for (int k = 0; k < num_ways; k++) begin
            if (m_valid[idx][k] && m_tag[idx][k] == addr[31:9]) begin
                hit = 1'b1;
                way = way_t'(k);
            end
        end
    endtask

    // Lowest invalid way, else the PLRU victim
    task automatic model_install(input addr_t line_addr);
        index_t idx;
        way_t   w;
        logic   found;
        idx   = line_addr[8:5];
        w     = model_victim(m_plru[idx]);
        found = 1'b0;
        for (int k = 0; k < num_ways; k++) begin
            if (!found && !m_valid[idx][k]) begin
                w     = way_t'(k);
                found = 1'b1;
            end
        end
        m_valid[idx][w] = 1'b1;
        m_tag[idx][w]   = line_addr[31:9];
        m_plru[idx]     = model_touch(m_plru[idx], w);
        exp_q.push_back(line_addr);
    endtask

    task automatic model_request(input addr_t addr, input logic pf,
                                 output logic hit, output int reads);
        addr_t line_addr;
        addr_t next_addr;
        way_t  w;
        logic  next_hit;
        line_addr = {addr[31:5], 5'b00000};
        model_find(addr, hit, w);
        reads = 0;
        if (hit) begin
            m_plru[addr[8:5]] = model_touch(m_plru[addr[8:5]], w);
        end else begin
            model_install(line_addr);
            reads = 1;
            if (pf) begin
                next_addr = line_addr + 32'd32;
                model_find(next_addr, next_hit, w);
                if (!next_hit) begin
                    model_install(next_addr);
                    reads = 2;
                end
            end
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input addr_t addr);
        if (got !== exp) begin
            $display("** Error at %0d ns: word at %08h is %08h, expected %08h",
                     $time, addr, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: mem_addr %08h, expected %08h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic do_request(input addr_t addr, input logic pf,
                              output word_t data, output int lat);
        @(posedge clk);
        cpu_read    <= 1'b1;
        cpu_addr    <= addr;
        prefetch_en <= pf;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!cpu_resp);
        data = cpu_rdata;
        @(posedge clk);
        cpu_read <= 1'b0;
        // Let a running prefetch install before the next request
        @(negedge clk);
        while (mem_read) begin
            @(negedge clk);
        end
    endtask

    task automatic run_one(input addr_t addr, input logic pf, output logic hit,
                           output int reads);
        word_t data;
        int    lat;
        int    m_reads;
        logic  m_hit;
        model_request(addr, pf, m_hit, m_reads);
        model_reads += m_reads;
        do_request(addr, pf, data, lat);
        reads = seen_q.size();
        hit   = (lat == 2);
        check_word(data, expected_word(addr), addr);
        check_count(reads, m_reads, "memory reads");
        for (int k = 0; k < exp_q.size() && k < seen_q.size(); k++) begin
            check_addr(seen_q[k], exp_q[k]);
        end
        if (m_hit) begin
            check_count(lat, 2, "hit latency");
        end else if (lat <= 2) begin
            $display("Request to %08h should have missed but was answered at once", addr);
            errors++;
        end
        exp_q.delete();
        seen_q.delete();
    endtask

    task automatic run_row(input int n);
        row_t r;
        logic hit;
        int   reads;
        int   errs_before;
        r = stim[n];
        errs_before = errors;
        run_one(r.addr, r.pf, hit, reads);
        check_count(reads, int'(r.reads), "memory reads from table");
        if (hit !== r.hit) begin
            $display("** Error at %0d ns: request to %08h gave a %s, expected a %s",
                     $time, r.addr, hit ? "hit" : "miss", r.hit ? "hit" : "miss");
            errors++;
        end
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("test %0d: addr %08h %s, %0d reads, %s", n + 1, r.addr,
                 hit ? "hit" : "miss", reads, errors == errs_before ? "ok" : "failed");
    endtask

    // 200 requests over sets 10 to 12 with six tags each
    task automatic run_random();
        addr_t addr;
        logic  pf;
        logic  hit;
        int    reads;
        int    model_total;
        int    start_model;
        int    start_reads;
        int    errs_before;
        start_model = model_reads;
        start_reads = mem_reads;
        errs_before = errors;
        for (int i = 0; i < num_random; i++) begin
            stim_rng = xorshift32(stim_rng);
            addr = {tag_t'(32'h40 + (stim_rng[31:16] % 6)),
                    index_t'(10 + (stim_rng[15:8] % 3)),
                    stim_rng[4:2], 2'b00};
            pf = stim_rng[24];
            run_one(addr, pf, hit, reads);
        end
        model_total = model_reads - start_model;
        check_count(mem_reads - start_reads, model_total, "total memory reads");
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("test %0d: %0d random reads, %0d memory reads, %s", num_rows + 1,
                 num_random, mem_reads - start_reads, errors == errs_before ? "ok" : "failed");
    endtask

    initial begin
        repeat (reset_cycles + row_cycles * (num_rows + num_random)) @(posedge clk);
        $display("Timeout: the cache stopped answering requests");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        prefetch_en = 1'b0;
        cpu_read    = 1'b0;
        cpu_addr    = '0;
        for (int s = 0; s < num_sets; s++) begin
            m_valid[s] = '0;
            m_plru[s]  = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < num_rows; n++) begin
            run_row(n);
        end
        run_random();
        $display("%0d tests, %0d failed, %0d errors", num_rows + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_icache

/* icache_top.sv */
`timescale 1ns/10ps

module icache_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     prefetch_en,
    input  logic                     cpu_read,
    input  cache_params_pkg::addr_t  cpu_addr,
    output cache_params_pkg::word_t  cpu_rdata,
    output logic                     cpu_resp,
    output logic                     mem_read,
    output cache_params_pkg::addr_t  mem_addr,
    input  cache_params_pkg::line_t  mem_rdata,
    input  logic                     mem_resp
);

    import cache_params_pkg::*;

    logic                        miss;
    addr_t                       miss_addr;
    logic                        hit_touch;
    index_t                      hit_index;
    logic [$clog2(num_ways)-1:0] hit_way;
    logic                        fill_touch;
    index_t                      fill_index;
    logic [$clog2(num_ways)-1:0] fill_way;
    index_t                      victim_index;
    logic [$clog2(num_ways)-1:0] victim_way;

    icache_stage_if stage_if (.clk(clk));
    icache_fill_if  fill_if ();

    icache_lookup lookup_i (
        .clk      (clk),
        .rst      (rst),
        .cpu_read (cpu_read),
        .cpu_addr (cpu_addr),
        .miss     (miss),
        .stage    (stage_if.source),
        .fill     (fill_if.array)
    );

    icache_hit_logic hit_i (
        .stage     (stage_if.sink),
        .cpu_rdata (cpu_rdata),
        .cpu_resp  (cpu_resp),
        .miss      (miss),
        .miss_addr (miss_addr),
        .hit_touch (hit_touch),
        .hit_index (hit_index),
        .hit_way   (hit_way)
    );

    icache_fill_ctrl fill_i (
        .clk          (clk),
        .rst          (rst),
        .prefetch_en  (prefetch_en),
        .miss         (miss),
        .miss_addr    (miss_addr),
        .mem_read     (mem_read),
        .mem_addr     (mem_addr),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .fill         (fill_if.controller),
        .victim_index (victim_index),
        .victim_way   (victim_way),
        .fill_touch   (fill_touch),
        .fill_index   (fill_index),
        .fill_way     (fill_way)
    );

    icache_plru plru_i (
        .clk          (clk),
        .rst          (rst),
        .hit_touch    (hit_touch),
        .hit_index    (hit_index),
        .hit_way      (hit_way),
        .fill_touch   (fill_touch),
        .fill_index   (fill_index),
        .fill_way     (fill_way),
        .victim_index (victim_index),
        .victim_way   (victim_way)
    );

endmodule : icache_top

/* icache_fill_ctrl.sv */
`timescale 1ns/10ps

module icache_fill_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     prefetch_en,
    input  logic                     miss,
    input  cache_params_pkg::addr_t  miss_addr,
    output logic                     mem_read,
    output cache_params_pkg::addr_t  mem_addr,
    input  cache_params_pkg::line_t  mem_rdata,
    input  logic                     mem_resp,
    icache_fill_if.controller        fill,
    output cache_params_pkg::index_t victim_index,
    input  cache_types_pkg::way_t    victim_way,
    output logic                     fill_touch,
    output cache_params_pkg::index_t fill_index,
    output cache_types_pkg::way_t    fill_way
);

    import cache_params_pkg::*;
    import cache_types_pkg::*;

    fill_state_t state_q;
    addr_t       fill_addr;
    addr_t       pend_addr;
    addr_t       next_addr;
    logic        pend;
    logic        inst_q;
    way_t        tgt_way;
    way_t        pick_way;
    line_t       line_q;

    function automatic logic same_line(addr_t a, addr_t b);
        return a[31:offset_bits] == b[31:offset_bits];
    endfunction

    assign next_addr = fill_addr + addr_t'(line_bytes);

    // Probe the pending miss, or the next line while prefetching
    assign fill.probe_addr = (state_q == prefetch_probe_s) ? next_addr : pend_addr;
    assign victim_index    = fill.probe_addr[offset_bits +: index_bits];

    // Lowest invalid way first, PLRU victim when the set is full
    always_comb begin
        pick_way = victim_way;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!fill.probe_valids[w]) begin
                pick_way = way_t'(w);
            end
        end
    end

    assign mem_read = (state_q == fill_demand_s) || (state_q == prefetch_s);
    assign mem_addr = fill_addr;

    // Install one cycle after mem_resp
    assign fill.install       = inst_q;
    assign fill.install_index = fill_addr[offset_bits +: index_bits];
    assign fill.install_tag   = fill_addr[offset_bits+index_bits +: tag_bits];
    assign fill.install_way   = tgt_way;
    assign fill.install_line  = line_q;

    // Also releases a miss that asked for the line being prefetched
    assign fill.install_demand = inst_q && ((pend && same_line(pend_addr, fill_addr))
                                 || (miss && same_line(miss_addr, fill_addr)));

    assign fill_touch = inst_q;
    assign fill_index = fill.install_index;
    assign fill_way   = tgt_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= fill_idle_s;
            pend    <= 1'b0;
            inst_q  <= 1'b0;
        end else begin
            inst_q <= 1'b0;
            if (fill.install_demand) begin
                pend <= 1'b0;
            end else if (miss) begin
                pend <= 1'b1;
            end

            case (state_q)
                fill_idle_s: begin
                    if (pend && !inst_q) begin
                        state_q <= fill_probe_s;
                    end
                end
                fill_probe_s: begin
                    state_q <= fill_demand_s;
                end
                fill_demand_s: begin
                    if (mem_resp) begin
                        inst_q  <= 1'b1;
                        state_q <= prefetch_en ? prefetch_probe_s : fill_idle_s;
                    end
                end
                prefetch_probe_s: begin
                    // Wait out the demand install, skip a line already held
                    if (!inst_q) begin
                        state_q <= fill.probe_hit ? fill_idle_s : prefetch_s;
                    end
                end
                prefetch_s: begin
                    if (mem_resp) begin
                        inst_q  <= 1'b1;
                        state_q <= fill_idle_s;
                    end
                end
                default: begin
                    state_q <= fill_idle_s;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == fill_probe_s) begin
            fill_addr <= {pend_addr[31:offset_bits], {offset_bits{1'b0}}};
            tgt_way   <= pick_way;
        end else if (state_q == prefetch_probe_s && !inst_q) begin
            fill_addr <= next_addr;
            tgt_way   <= pick_way;
        end
        if (mem_read && mem_resp) begin
            line_q <= mem_rdata;
        end
        if (miss) begin
            pend_addr <= miss_addr;
        end
    end

    a_read_held: assert property (
        @(posedge clk) disable iff (rst) mem_read && !mem_resp |=> mem_read
    );

endmodule : icache_fill_ctrl

/* icache_hit_logic.sv */
`timescale 1ns/10ps

module icache_hit_logic (
    icache_stage_if.sink             stage,
    output cache_params_pkg::word_t  cpu_rdata,
    output logic                     cpu_resp,
    output logic                     miss,
    output cache_params_pkg::addr_t  miss_addr,
    output logic                     hit_touch,
    output cache_params_pkg::index_t hit_index,
    output cache_types_pkg::way_t    hit_way
);

    import cache_params_pkg::*;
    import cache_types_pkg::*;

    tag_t       req_tag;
    offset_t    req_offset;
    valid_vec_t hits;
    logic       any_hit;
    logic [2:0] word_sel;

    assign req_tag    = stage.stage_addr[offset_bits+index_bits +: tag_bits];
    assign req_offset = stage.stage_addr[offset_bits-1:0];
    assign word_sel   = req_offset[4:2];

    // Tag match against the valid ways
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            hits[w] = stage.way_valids[w] && stage.way_tags[w] == req_tag;
            if (hits[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign any_hit   = |hits;
    assign cpu_rdata = stage.way_lines[hit_way][word_bits*word_sel +: word_bits];

    // Response or miss in the compare cycle
    assign cpu_resp  = stage.stage_valid && any_hit;
    assign miss      = stage.stage_valid && !any_hit;
    assign miss_addr = stage.stage_addr;

    assign hit_touch = cpu_resp;
    assign hit_index = stage.stage_addr[offset_bits +: index_bits];

    // A line is never installed twice in one set
    a_single_hit: assert property (
        @(posedge stage.clk) stage.stage_valid |-> $onehot0(hits)
    );

endmodule : icache_hit_logic

/* icache_lookup.sv */
`timescale 1ns/10ps

module icache_lookup (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cpu_read,
    input  cache_params_pkg::addr_t  cpu_addr,
    input  logic                     miss,
    icache_stage_if.source           stage,
    icache_fill_if.array             fill
);

    import cache_params_pkg::*;
    import cache_types_pkg::*;

    valid_vec_t valid_arr [num_sets];
    tag_t       tag_arr   [num_sets][num_ways];
    line_t      line_arr  [num_sets][num_ways];

    logic   capture;
    logic   miss_wait;
    index_t cap_index;
    index_t probe_index;
    tag_t   probe_tag;

    // No capture while a request is in compare, a miss waits, or an install writes
    assign capture   = cpu_read && !stage.stage_valid && !miss_wait && !fill.install;
    assign cap_index = cpu_addr[offset_bits +: index_bits];

    always_ff @(posedge clk) begin
        if (rst) begin
            stage.stage_valid <= 1'b0;
            miss_wait         <= 1'b0;
        end else begin
            stage.stage_valid <= capture;
            if (fill.install && fill.install_demand) begin
                miss_wait <= 1'b0;
            end else if (miss) begin
                miss_wait <= 1'b1;
            end
        end
    end

    // Registered read of the indexed set
    always_ff @(posedge clk) begin
        if (capture) begin
            stage.stage_addr <= cpu_addr;
            stage.way_tags   <= tag_arr[cap_index];
            stage.way_valids <= valid_arr[cap_index];
            stage.way_lines  <= line_arr[cap_index];
        end
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_arr[s] <= '0;
            end
        end else if (fill.install) begin
            valid_arr[fill.install_index][fill.install_way] <= 1'b1;
        end
    end

    // Tag and line storage
    always_ff @(posedge clk) begin
        if (fill.install) begin
            tag_arr[fill.install_index][fill.install_way]  <= fill.install_tag;
            line_arr[fill.install_index][fill.install_way] <= fill.install_line;
        end
    end

    // Combinational probe for the fill controller
    assign probe_index       = fill.probe_addr[offset_bits +: index_bits];
    assign probe_tag         = fill.probe_addr[offset_bits+index_bits +: tag_bits];
    assign fill.probe_valids = valid_arr[probe_index];

    always_comb begin
        fill.probe_hit = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            if (valid_arr[probe_index][w] && tag_arr[probe_index][w] == probe_tag) begin
                fill.probe_hit = 1'b1;
            end
        end
    end

    a_install_way_known: assert property (
        @(posedge clk) disable iff (rst) fill.install |-> !$isunknown(fill.install_way)
    );

endmodule : icache_lookup

/* icache_plru.sv */
`timescale 1ns/10ps

module icache_plru (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hit_touch,
    input  cache_params_pkg::index_t hit_index,
    input  cache_types_pkg::way_t    hit_way,
    input  logic                     fill_touch,
    input  cache_params_pkg::index_t fill_index,
    input  cache_types_pkg::way_t    fill_way,
    input  cache_params_pkg::index_t victim_index,
    output cache_types_pkg::way_t    victim_way
);

    import cache_params_pkg::*;
    import cache_types_pkg::*;

    plru_t plru_q [num_sets];

    // Point the tree away from the way just used
    function automatic plru_t touch(plru_t p, way_t w);
        plru_t n;
        n = p;
        n[0] = !w[1];
        if (w[1]) begin
            n[2] = !w[0];
        end else begin
            n[1] = !w[0];
        end
        return n;
    endfunction

    assign victim_way = plru_q[victim_index][0] ? {1'b1, plru_q[victim_index][2]}
                                                : {1'b0, plru_q[victim_index][1]};

    // Fill touch comes last so it wins on a shared set
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                plru_q[s] <= '0;
            end
        end else begin
            if (hit_touch) begin
                plru_q[hit_index] <= touch(plru_q[hit_index], hit_way);
            end
            if (fill_touch) begin
                plru_q[fill_index] <= touch(plru_q[fill_index], fill_way);
            end
        end
    end

    a_touch_clash: assert property (
        @(posedge clk) disable iff (rst) !(hit_touch && fill_touch && hit_index == fill_index)
    ) else $warning("hit and fill touch the same PLRU set");

endmodule : icache_plru

/* icache_fill_if.sv */
`timescale 1ns/10ps

interface icache_fill_if;

    import cache_params_pkg::*;

    // Line install
    logic                         install;
    logic                         install_demand;
    index_t                       install_index;
    logic [$clog2(num_ways)-1:0]  install_way;
    tag_t                         install_tag;
    line_t                        install_line;

    // Set probe
    addr_t                        probe_addr;
    logic                         probe_hit;
    logic [num_ways-1:0]          probe_valids;

    modport controller (
        output install, install_demand, install_index, install_way, install_tag,
        output install_line, probe_addr,
        input  probe_hit, probe_valids
    );

    modport array (
        input  install, install_demand, install_index, install_way, install_tag,
        input  install_line, probe_addr,
        output probe_hit, probe_valids
    );

endinterface : icache_fill_if

/* icache_stage_if.sv */
`timescale 1ns/10ps

interface icache_stage_if (input logic clk);

    import cache_params_pkg::*;

    logic                 stage_valid;
    addr_t                stage_addr;
    tag_t                 way_tags [num_ways];
    logic [num_ways-1:0]  way_valids;
    line_t                way_lines [num_ways];

    // Lookup stage drives the registered set
    modport source (
        output stage_valid, stage_addr, way_tags, way_valids, way_lines
    );

    // Compare stage reads it
    modport sink (
        input clk, stage_valid, stage_addr, way_tags, way_valids, way_lines
    );

endinterface : icache_stage_if

/* cache_types_pkg.sv */
package cache_types_pkg;

    import cache_params_pkg::*;

    // Way number within a set
    typedef logic [$clog2(num_ways)-1:0] way_t;

    // Tree PLRU bits of one set
    // bit 0 is the root, bit 1 picks within ways 0/1, bit 2 within ways 2/3
    typedef logic [num_ways-2:0] plru_t;

    // One valid flag per way, also the probe result
    typedef logic [num_ways-1:0] valid_vec_t;

    // Fill controller states
    typedef enum logic [2:0] {
        fill_idle_s,
        fill_probe_s,
        fill_demand_s,
        prefetch_probe_s,
        prefetch_s
    } fill_state_t;

endpackage : cache_types_pkg

/* cache_params_pkg.sv */
package cache_params_pkg;

    // Cache geometry
    localparam int num_ways    = 4;
    localparam int num_sets    = 16;
    localparam int line_bytes  = 32;
    localparam int offset_bits = 5;
    localparam int index_bits  = 4;
    localparam int tag_bits    = 23;
    localparam int line_bits   = 256;
    localparam int word_bits   = 32;

    // Byte address, split as tag | index | offset
    typedef logic [31:0] addr_t;

    // Bits 31 to 9 of the address
    typedef logic [tag_bits-1:0] tag_t;

    // Bits 8 to 5 of the address
    typedef logic [index_bits-1:0] index_t;

    // Byte within a line
    typedef logic [offset_bits-1:0] offset_t;

    // One full cache line
    typedef logic [line_bits-1:0] line_t;

    // One instruction word
    typedef logic [word_bits-1:0] word_t;

endpackage : cache_params_pkg
